//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbRvExecPipe
OBJ_DIR   ?= obj_dir
FLIST     ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv src/*.svh verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
+incdir+src
src/rvPkg.sv
src/decodeStage.sv
src/executeStage.sv
src/writebackStage.sv
src/rvExecPipe.sv
verif/retireChecker.sv
verif/tbRvExecPipe.sv

//--- src/decodeStage.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module decodeStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    input  rvPkg::issueReq_s  in,
    output logic              outValid,
    output rvPkg::decoded_s   out
);

    rvPkg::instWord_u       inst;
    rvPkg::decoded_s        dec;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`RV_XLEN-1:0]    immI;
    logic [`RV_XLEN-1:0]    immB;
    logic [`RV_XLEN-1:0]    immU;
    logic [`RV_XLEN-1:0]    immJ;

    assign inst   = in.inst;
    assign opcode = inst.rType.opcode;
    assign funct3 = inst.rType.funct3;
    assign funct7 = inst.rType.funct7;

    assign immI = {{52{inst.iType.imm11_0[11]}}, inst.iType.imm11_0};
    assign immB = {{51{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                   inst.bType.imm10_5, inst.bType.imm4_1, 1'b0};
    assign immU = {{32{inst.uType.imm31_12[19]}}, inst.uType.imm31_12, 12'b0};
    assign immJ = {{43{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19_12,
                   inst.jType.imm11, inst.jType.imm10_1, 1'b0};

    always_comb begin
        dec          = '0;
        dec.aluOp    = `RV_ALU_ADD;
        dec.selA     = 1'b1;
        dec.selB     = 1'b1;
        dec.brFunct3 = funct3;
        dec.rd       = inst.rType.rd;
        dec.imm      = immI;
        dec.pc       = in.pc;
        dec.rs1Val   = in.rs1Val;
        dec.rs2Val   = in.rs2Val;
        case (opcode)
            `RV_OP_OP: begin
                dec.writeRd = 1'b1;
                case (funct7)
                    `RV_F7_BASE: case (funct3)
                        `RV_F3_ADD:  dec.aluOp = `RV_ALU_ADD;
                        `RV_F3_SLL:  dec.aluOp = `RV_ALU_SLL;
                        `RV_F3_SLT:  dec.aluOp = `RV_ALU_SLT;
                        `RV_F3_SLTU: dec.aluOp = `RV_ALU_SLTU;
                        `RV_F3_XOR:  dec.aluOp = `RV_ALU_XOR;
                        `RV_F3_SR:   dec.aluOp = `RV_ALU_SRL;
                        `RV_F3_OR:   dec.aluOp = `RV_ALU_OR;
                        default:     dec.aluOp = `RV_ALU_AND;
                    endcase
                    `RV_F7_ALT: case (funct3)
                        `RV_F3_ADD: dec.aluOp = `RV_ALU_SUB;
                        `RV_F3_SR:  dec.aluOp = `RV_ALU_SRA;
                        default:    dec.illegal = 1'b1;
                    endcase
                    default: dec.illegal = 1'b1; // mul/div not handled
                endcase
            end
            `RV_OP_OP_IMM: begin
                dec.writeRd = 1'b1;
                dec.selB    = 1'b0;
                case (funct3)
                    `RV_F3_ADD:  dec.aluOp = `RV_ALU_ADD;
                    `RV_F3_SLT:  dec.aluOp = `RV_ALU_SLT;
                    `RV_F3_SLTU: dec.aluOp = `RV_ALU_SLTU;
                    `RV_F3_XOR:  dec.aluOp = `RV_ALU_XOR;
                    `RV_F3_OR:   dec.aluOp = `RV_ALU_OR;
                    `RV_F3_AND:  dec.aluOp = `RV_ALU_AND;
                    `RV_F3_SLL: begin
                        dec.aluOp   = `RV_ALU_SLL;
                        dec.illegal = (funct7[6:1] != `RV_F7_BASE >> 1); // bit 25 is shamt[5]
                    end
                    default: begin
                        if (funct7[6:1] == (`RV_F7_ALT >> 1)) begin
                            dec.aluOp = `RV_ALU_SRA;
                        end else begin
                            dec.aluOp   = `RV_ALU_SRL;
                            dec.illegal = (funct7[6:1] != `RV_F7_BASE >> 1);
                        end
                    end
                endcase
            end
            `RV_OP_OP_32: begin
                dec.writeRd = 1'b1;
                dec.word32  = 1'b1;
                case ({funct7, funct3})
                    {`RV_F7_BASE, `RV_F3_ADD}: dec.aluOp = `RV_ALU_ADD;
                    {`RV_F7_BASE, `RV_F3_SLL}: dec.aluOp = `RV_ALU_SLL;
                    {`RV_F7_BASE, `RV_F3_SR}:  dec.aluOp = `RV_ALU_SRL;
                    {`RV_F7_ALT, `RV_F3_ADD}:  dec.aluOp = `RV_ALU_SUB;
                    {`RV_F7_ALT, `RV_F3_SR}:   dec.aluOp = `RV_ALU_SRA;
                    default:                   dec.illegal = 1'b1;
                endcase
            end
            `RV_OP_OP_IMM_32: begin
                dec.writeRd = 1'b1;
                dec.word32  = 1'b1;
                dec.selB    = 1'b0;
                if (funct3 == `RV_F3_ADD) begin
                    dec.aluOp = `RV_ALU_ADD; // addiw, funct7 is immediate
                end else begin
                    case ({funct7, funct3})
                        {`RV_F7_BASE, `RV_F3_SLL}: dec.aluOp = `RV_ALU_SLL;
                        {`RV_F7_BASE, `RV_F3_SR}:  dec.aluOp = `RV_ALU_SRL;
                        {`RV_F7_ALT, `RV_F3_SR}:   dec.aluOp = `RV_ALU_SRA;
                        default:                   dec.illegal = 1'b1;
                    endcase
                end
            end
            `RV_OP_LUI: begin
                dec.writeRd = 1'b1;
                dec.selB    = 1'b0;
                dec.imm     = immU;
                dec.aluOp   = `RV_ALU_PASS_B;
            end
            `RV_OP_AUIPC: begin
                dec.writeRd = 1'b1;
                dec.selA    = 1'b0;
                dec.selB    = 1'b0;
                dec.imm     = immU;
            end
            `RV_OP_JAL: begin
                dec.writeRd = 1'b1;
                dec.isJal   = 1'b1;
                dec.imm     = immJ;
            end
            `RV_OP_JALR: begin
                dec.writeRd = 1'b1;
                dec.isJalr  = 1'b1;
                dec.illegal = (funct3 != 3'b000);
            end
            `RV_OP_BRANCH: begin
                dec.isBranch = 1'b1;
                dec.imm      = immB;
                dec.illegal  = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            default: dec.illegal = 1'b1; // loads, stores, system
        endcase
        if (dec.illegal) begin // falls through to pc+4
            dec.writeRd  = 1'b0;
            dec.isBranch = 1'b0;
            dec.isJal    = 1'b0;
            dec.isJalr   = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            out <= dec;
        end
    end

    // issue strobe never X out of reset
    validKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(inValid));

endmodule

//--- src/executeStage.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module executeStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    input  rvPkg::decoded_s   in,
    output logic              outValid,
    output rvPkg::executed_s  out
);

    logic [`RV_XLEN-1:0]    opA;
    logic [`RV_XLEN-1:0]    opB;
    logic [5:0]             shamt;
    logic [`RV_XLEN-1:0]    srlSrc;
    logic [`RV_XLEN-1:0]    sraSrc;
    logic [`RV_XLEN-1:0]    aluResult;
    logic [`RV_XLEN-1:0]    link;
    logic [`RV_XLEN-1:0]    jalrTarget;
    logic [`RV_XLEN-1:0]    nextPc;
    logic                   taken;

    assign opA   = in.selA ? in.rs1Val : in.pc;
    assign opB   = in.selB ? in.rs2Val : in.imm;
    assign shamt = in.word32 ? {1'b0, opB[4:0]} : opB[5:0];

    // W right shifts only see the low word of rs1
    assign srlSrc = in.word32 ? {32'b0, opA[31:0]} : opA;
    assign sraSrc = in.word32 ? {{32{opA[31]}}, opA[31:0]} : opA;

    always_comb begin
        case (in.aluOp)
            `RV_ALU_ADD:    aluResult = opA + opB;
            `RV_ALU_SUB:    aluResult = opA - opB;
            `RV_ALU_SLL:    aluResult = opA << shamt;
            `RV_ALU_SRL:    aluResult = srlSrc >> shamt;
            `RV_ALU_SRA:    aluResult = $signed(sraSrc) >>> shamt;
            `RV_ALU_XOR:    aluResult = opA ^ opB;
            `RV_ALU_OR:     aluResult = opA | opB;
            `RV_ALU_AND:    aluResult = opA & opB;
            `RV_ALU_SLT:    aluResult = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            `RV_ALU_SLTU:   aluResult = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            `RV_ALU_PASS_B: aluResult = opB; // lui
            default:        aluResult = '0;
        endcase
    end

    always_comb begin
        case (in.brFunct3)
            `RV_F3_BEQ:  taken = (in.rs1Val == in.rs2Val);
            `RV_F3_BNE:  taken = (in.rs1Val != in.rs2Val);
            `RV_F3_BLT:  taken = ($signed(in.rs1Val) < $signed(in.rs2Val));
            `RV_F3_BGE:  taken = ($signed(in.rs1Val) >= $signed(in.rs2Val));
            `RV_F3_BLTU: taken = (in.rs1Val < in.rs2Val);
            `RV_F3_BGEU: taken = (in.rs1Val >= in.rs2Val);
            default:     taken = 1'b0;
        endcase
    end

    assign link       = in.pc + 64'd4;
    assign jalrTarget = in.rs1Val + in.imm;

    always_comb begin
        if ((in.isBranch && taken) || in.isJal) begin
            nextPc = in.pc + in.imm;
        end else if (in.isJalr) begin
            nextPc = {jalrTarget[`RV_XLEN-1:1], 1'b0};
        end else begin
            nextPc = link;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            out.result  <= aluResult;
            out.link    <= link;
            out.nextPc  <= nextPc;
            out.isJump  <= in.isJal || in.isJalr;
            out.word32  <= in.word32;
            out.writeRd <= in.writeRd;
            out.rd      <= in.rd;
            out.illegal <= in.illegal;
        end
    end

    // decode must never flag one word as both
    branchJalExclusive: assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> !(in.isBranch && in.isJal));

endmodule

//--- src/rvExecPipe.sv
`timescale 1ns/100ps

module rvExecPipe (
    input  logic              clk,
    input  logic              arstN,
    input  logic              issueValid,
    input  rvPkg::issueReq_s  issue,
    output logic              retireValid,
    output rvPkg::retire_s    retire
);

    logic               decValid;
    rvPkg::decoded_s    decoded;
    logic               exeValid;
    rvPkg::executed_s   executed;

    decodeStage i_decode (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (issueValid),
        .in       (issue),
        .outValid (decValid),
        .out      (decoded)
    );

    executeStage i_execute (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (decValid),
        .in       (decoded),
        .outValid (exeValid),
        .out      (executed)
    );

    writebackStage i_writeback (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (exeValid),
        .in       (executed),
        .outValid (retireValid),
        .out      (retire)
    );

endmodule

//--- src/rvPkg.sv
`include "rv_consts.svh"

package rvPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_s;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sType_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_s;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_s;

    typedef union packed {
        rType_s rType;
        iType_s iType;
        sType_s sType;
        bType_s bType;
        uType_s uType;
        jType_s jType;
    } instWord_u;

    typedef struct packed {
        instWord_u              inst;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    rs1Val;
        logic [`RV_XLEN-1:0]    rs2Val;
    } issueReq_s;

    typedef struct packed {
        logic [3:0]             aluOp;
        logic                   selA; // 1 rs1, 0 pc
        logic                   selB; // 1 rs2, 0 imm
        logic                   isBranch;
        logic                   isJal;
        logic                   isJalr;
        logic [2:0]             brFunct3;
        logic                   word32;
        logic                   writeRd;
        logic [4:0]             rd;
        logic                   illegal;
        logic [`RV_XLEN-1:0]    imm;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    rs1Val;
        logic [`RV_XLEN-1:0]    rs2Val;
    } decoded_s;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    result;
        logic [`RV_XLEN-1:0]    link;
        logic [`RV_XLEN-1:0]    nextPc;
        logic                   isJump;
        logic                   word32;
        logic                   writeRd;
        logic [4:0]             rd;
        logic                   illegal;
    } executed_s;

    typedef struct packed {
        logic                   writeRd;
        logic [4:0]             rd;
        logic [`RV_XLEN-1:0]    result;
        logic [`RV_XLEN-1:0]    nextPc;
        logic                   illegal;
    } retire_s;

endpackage

//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN 64

// major opcodes
`define RV_OP_OP        7'b0110011
`define RV_OP_OP_IMM    7'b0010011
`define RV_OP_OP_32     7'b0111011
`define RV_OP_OP_IMM_32 7'b0011011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011

`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101 // srl and sra share it
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`define RV_F7_BASE 7'h00
`define RV_F7_ALT  7'h20 // sub, sra

`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SRL    4'd3
`define RV_ALU_SRA    4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_OR     4'd6
`define RV_ALU_AND    4'd7
`define RV_ALU_SLT    4'd8
`define RV_ALU_SLTU   4'd9
`define RV_ALU_PASS_B 4'd10

`endif

//--- src/writebackStage.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module writebackStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    input  rvPkg::executed_s  in,
    output logic              outValid,
    output rvPkg::retire_s    out
);

    logic [`RV_XLEN-1:0]    result;
    logic                   writeRd;

    always_comb begin
        if (in.isJump) begin
            result = in.link;
        end else if (in.word32) begin
            result = {{32{in.result[31]}}, in.result[31:0]};
        end else begin
            result = in.result;
        end
    end

    assign writeRd = in.writeRd && !in.illegal && (in.rd != 5'd0); // x0 never written

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            out.writeRd <= writeRd;
            out.rd      <= in.rd;
            out.result  <= result;
            out.nextPc  <= in.nextPc;
            out.illegal <= in.illegal;
        end
    end

endmodule

//--- verif/retireChecker.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module retireChecker (
    input  logic              clk,
    input  logic              arstN,
    input  logic              issueValid,
    input  rvPkg::issueReq_s  issue,
    input  logic              retireValid,
    input  rvPkg::retire_s    retire,
    input  logic [127:0]      testName,
    output int                errCount,
    output int                checkCount,
    output int                pending
);

    typedef struct packed {
        rvPkg::retire_s rec;
        logic [31:0]    cycle;
        logic [127:0]   name;
        logic [63:0]    pc;
    } expEntry_s;

    expEntry_s  expQ[$];
    int         sampleCount;

    // ISA reference for one instruction
    function automatic rvPkg::retire_s predict(rvPkg::issueReq_s req);
        logic [31:0]    w;
        logic [6:0]     op;
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic [63:0]    a;
        logic [63:0]    b;
        logic [63:0]    immI;
        logic [63:0]    immU;
        logic [63:0]    immB;
        logic [63:0]    immJ;
        logic [63:0]    r;
        logic [63:0]    nextPc;
        logic [31:0]    r32;
        logic           legal;
        logic           noDest;
        logic           taken;
        rvPkg::retire_s e;
        w      = req.inst;
        op     = w[6:0];
        f3     = w[14:12];
        f7     = w[31:25];
        a      = req.rs1Val;
        immI   = {{52{w[31]}}, w[31:20]};
        immU   = {{32{w[31]}}, w[31:12], 12'h000};
        immB   = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immJ   = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        legal  = 1'b1;
        noDest = 1'b0;
        taken  = 1'b0;
        r      = '0;
        r32    = '0;
        nextPc = req.pc + 64'd4;
        case (op)
            `RV_OP_OP, `RV_OP_OP_IMM: begin
                b = (op == `RV_OP_OP) ? req.rs2Val : immI;
                if (op == `RV_OP_OP) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end else if (f3 == 3'd1) begin
                    legal = (w[31:26] == 6'h00);
                end else if (f3 == 3'd5) begin
                    legal = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
                end
                case (f3)
                    3'd0: r = (op == `RV_OP_OP && w[30]) ? a - b : a + b;
                    3'd1: r = a << b[5:0];
                    3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    3'd3: r = (a < b) ? 64'd1 : 64'd0;
                    3'd4: r = a ^ b;
                    3'd5: begin
                        if (w[30]) r = $signed(a) >>> b[5:0];
                        else r = a >> b[5:0];
                    end
                    3'd6: r = a | b;
                    default: r = a & b;
                endcase
            end
            `RV_OP_OP_32, `RV_OP_OP_IMM_32: begin
                b = (op == `RV_OP_OP_32) ? req.rs2Val : immI;
                if (op == `RV_OP_OP_32) begin
                    legal = (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
                            (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end else begin
                    legal = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                            (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
                end
                case (f3)
                    3'd0: r32 = (op == `RV_OP_OP_32 && w[30]) ? a[31:0] - b[31:0]
                                                               : a[31:0] + b[31:0];
                    3'd1: r32 = a[31:0] << b[4:0];
                    default: begin
                        if (w[30]) r32 = $signed(a[31:0]) >>> b[4:0];
                        else r32 = a[31:0] >> b[4:0];
                    end
                endcase
                r = {{32{r32[31]}}, r32};
            end
            `RV_OP_LUI:   r = immU;
            `RV_OP_AUIPC: r = req.pc + immU;
            `RV_OP_JAL: begin
                r      = req.pc + 64'd4;
                nextPc = req.pc + immJ;
            end
            `RV_OP_JALR: begin
                legal  = (f3 == 3'd0);
                r      = req.pc + 64'd4;
                nextPc = (a + immI) & ~64'd1;
            end
            `RV_OP_BRANCH: begin
                noDest = 1'b1;
                legal  = (f3 != 3'd2) && (f3 != 3'd3);
                case (f3)
                    3'd0: taken = (a == req.rs2Val);
                    3'd1: taken = (a != req.rs2Val);
                    3'd4: taken = ($signed(a) < $signed(req.rs2Val));
                    3'd5: taken = ($signed(a) >= $signed(req.rs2Val));
                    3'd6: taken = (a < req.rs2Val);
                    default: taken = (a >= req.rs2Val);
                endcase
                if (taken) nextPc = req.pc + immB;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) nextPc = req.pc + 64'd4;
        e.writeRd = legal && !noDest && (w[11:7] != 5'd0);
        e.rd      = w[11:7];
        e.result  = r;
        e.nextPc  = nextPc;
        e.illegal = !legal;
        return e;
    endfunction

    // rd and result only matter when a register is written
    function automatic logic sameRecord(rvPkg::retire_s expRec, rvPkg::retire_s actRec);
        logic same;
        same = (expRec.writeRd === actRec.writeRd) && (expRec.nextPc === actRec.nextPc) &&
               (expRec.illegal === actRec.illegal);
        if (expRec.writeRd) begin
            same = same && (expRec.rd === actRec.rd) && (expRec.result === actRec.result);
        end
        return same;
    endfunction

    initial begin
        errCount    = 0;
        checkCount  = 0;
        pending     = 0;
        sampleCount = 0;
    end

    always @(negedge clk) begin
        expEntry_s e;
        sampleCount = sampleCount + 1;
        if (arstN && retireValid) begin
            if (expQ.size() == 0) begin
                $display("%0s: a record retired while no instruction was outstanding",
                         testName);
                errCount = errCount + 1;
            end else begin
                e          = expQ.pop_front();
                checkCount = checkCount + 1;
                if (!sameRecord(e.rec, retire)) begin
                    $write("FAIL %0s pc %h: expected wr=%b rd=%0d res=%h npc=%h ill=%b,",
                           e.name, e.pc, e.rec.writeRd, e.rec.rd, e.rec.result,
                           e.rec.nextPc, e.rec.illegal);
                    $display(" actual wr=%b rd=%0d res=%h npc=%h ill=%b", retire.writeRd,
                             retire.rd, retire.result, retire.nextPc, retire.illegal);
                    errCount = errCount + 1;
                end
                if (sampleCount - int'(e.cycle) != 3) begin
                    $display("FAIL %0s pc %h: latency expected 3 actual %0d", e.name, e.pc,
                             sampleCount - int'(e.cycle));
                    errCount = errCount + 1;
                end
            end
        end
        if (arstN && issueValid) begin
            e.rec   = predict(issue);
            e.cycle = sampleCount;
            e.name  = testName;
            e.pc    = issue.pc;
            expQ.push_back(e);
        end
        pending = expQ.size();
    end

endmodule

//--- verif/tbRvExecPipe.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module tbRvExecPipe;

    localparam int NumTests      = 6;
    localparam int IssuesPerTest = 150;
    localparam int CycleLimit    = NumTests * IssuesPerTest * 2 + 100;

    logic               clk;
    logic               arstN;
    logic               issueValid;
    rvPkg::issueReq_s   issue;
    logic               retireValid;
    rvPkg::retire_s     retire;
    logic [127:0]       testName;
    int                 errCount;
    int                 checkCount;
    int                 pending;
    int                 seed;
    int                 cycles = 0;
    int                 failedTests = 0;

    rvExecPipe i_dut (
        .clk         (clk),
        .arstN       (arstN),
        .issueValid  (issueValid),
        .issue       (issue),
        .retireValid (retireValid),
        .retire      (retire)
    );

    retireChecker i_chk (
        .clk         (clk),
        .arstN       (arstN),
        .issueValid  (issueValid),
        .issue       (issue),
        .retireValid (retireValid),
        .retire      (retire),
        .testName    (testName),
        .errCount    (errCount),
        .checkCount  (checkCount),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CycleLimit) begin
            $display("timeout: run went past %0d cycles, %0d records outstanding",
                     CycleLimit, pending);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic int pick(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // operands lean on sign and word boundaries
    function automatic logic [63:0] randValue();
        logic [63:0] v;
        v = {$random(seed), $random(seed)};
        case (pick(10))
            0: v = 64'h7fff_ffff_ffff_ffff;
            1: v = 64'h8000_0000_0000_0000;
            2: v = '1;
            3: v = 64'h0000_0000_8000_0000;
            4: v = '0;
            default: ;
        endcase
        return v;
    endfunction

    function automatic rvPkg::instWord_u makeInst(int cls, logic zeroRd);
        rvPkg::instWord_u w;
        logic [2:0]       f3;
        w  = $random(seed); // fields below overwrite parts of it
        f3 = 3'(pick(8));
        case (cls)
            0: begin
                if (f3 == 3'd1 || f3 == 3'd5) f3 = f3 + 3'd1; // skip shifts
                if (pick(2) != 0) begin
                    w.rType.opcode = `RV_OP_OP;
                    w.rType.funct7 = (f3 == 3'd0 && pick(2) != 0) ? `RV_F7_ALT : `RV_F7_BASE;
                end else begin
                    w.iType.opcode = `RV_OP_OP_IMM;
                end
            end
            1: begin
                f3 = (pick(3) == 0) ? 3'd0 : ((pick(2) != 0) ? 3'd1 : 3'd5);
                case (pick(4))
                    0: w.rType.opcode = `RV_OP_OP;
                    1: w.rType.opcode = `RV_OP_OP_IMM;
                    2: w.rType.opcode = `RV_OP_OP_32;
                    default: w.rType.opcode = `RV_OP_OP_IMM_32;
                endcase
                if (w.rType.opcode == `RV_OP_OP_IMM && f3 != 3'd0) begin
                    w.rType.funct7[6:1] = (f3 == 3'd5 && pick(2) != 0) ? 6'h10 : 6'h00;
                end else if (f3 != 3'd0 || w.rType.opcode[5]) begin
                    w.rType.funct7 = (f3 != 3'd1 && pick(2) != 0) ? `RV_F7_ALT : `RV_F7_BASE;
                end
            end
            2: w.uType.opcode = (pick(2) != 0) ? `RV_OP_LUI : `RV_OP_AUIPC;
            3: begin
                case (pick(3))
                    0: begin
                        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
                        w.bType.opcode = `RV_OP_BRANCH;
                    end
                    1: w.jType.opcode = `RV_OP_JAL;
                    default: begin
                        w.iType.opcode = `RV_OP_JALR;
                        f3 = 3'd0;
                    end
                endcase
            end
            default: begin
                case (pick(5))
                    0: w.rType.opcode = 7'b0000011; // load
                    1: w.rType.opcode = 7'b0100011; // store
                    2: w.rType.opcode = 7'b1110011; // system
                    3: w.rType.opcode = 7'b0001111; // fence
                    default: w.rType.opcode = `RV_OP_OP; // random funct7
                endcase
            end
        endcase
        w.rType.funct3 = f3;
        if (zeroRd) w.rType.rd = 5'd0;
        return w;
    endfunction

    // clsSel 0..3 fixed class, 4 illegal or x0, 5 anything
    task automatic runTest(input logic [127:0] name, input int clsSel);
        int   n;
        int   burst;
        int   cls;
        int   errBefore;
        int   checkBefore;
        logic zeroRd;
        n           = 0;
        errBefore   = errCount;
        checkBefore = checkCount;
        testName    = name;
        while (n < IssuesPerTest) begin
            burst = 1 + pick(8);
            while (burst > 0 && n < IssuesPerTest) begin
                cls    = clsSel;
                zeroRd = 1'b0;
                if (clsSel == 4) begin
                    zeroRd = (pick(2) != 0);
                    cls    = zeroRd ? pick(4) : 4;
                end else if (clsSel == 5) begin
                    cls = pick(5);
                end
                issue.inst   = makeInst(cls, zeroRd);
                issue.pc     = {$random(seed), $random(seed)} & ~64'd3;
                issue.rs1Val = randValue();
                issue.rs2Val = (pick(4) == 0) ? issue.rs1Val : randValue(); // equal operands
                issueValid   = 1'b1;
                @(posedge clk);
                #1;
                burst = burst - 1;
                n     = n + 1;
            end
            issueValid = 1'b0;
            if (pick(2) != 0) begin
                @(posedge clk);
                #1;
            end
        end
        issueValid = 1'b0;
        while (pending != 0) @(posedge clk); // timeout covers a stuck pipe
        #1;
        if (errCount != errBefore) failedTests = failedTests + 1;
        $display("%0s: %0d records checked, %0d errors", name,
                 checkCount - checkBefore, errCount - errBefore);
    endtask

    initial begin
        seed       = 16006;
        arstN      = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        testName   = "reset";
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        runTest("alu_arith", 0);
        runTest("shift_word", 1);
        runTest("lui_auipc", 2);
        runTest("branch_jump", 3);
        runTest("illegal_x0", 4);
        runTest("mixed_burst", 5);
        $display("tests run %0d, passed %0d, failed %0d", NumTests,
                 NumTests - failedTests, failedTests);
        if (failedTests == 0 && errCount == 0 && pending == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
